//--- Makefile
# Verilator build and run of the FU cluster testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+include
hw/fu_pkg.sv
hw/alu_lane.sv
hw/mult_pipe.sv
hw/cdb_arbiter.sv
hw/fu_cluster.sv
verif/clock_gen.sv
verif/fu_checker.sv
verif/fu_tb.sv

//--- hw/alu_lane.sv
// one ALU lane, handles OP and OP-IMM only; anything else completes with 0
// hold freezes both pipeline registers, squash overrides hold
`include "fu_cfg.svh"

module alu_lane (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  squash,
    input  logic                  hold,     // no bus slot this cycle
    input  fu_pkg::is_ex_packet_t issue,
    output fu_pkg::ex_cp_packet_t result    // execute/complete register
);

    fu_pkg::is_ex_packet_t is_ex;       // issue/execute register
    fu_pkg::inst_word_t    inst;
    fu_pkg::data_t         opa;
    fu_pkg::data_t         opb;
    fu_pkg::data_t         alu_out;
    logic [4:0]            shamt;
    logic                  is_op;
    logic                  is_op_imm;
    logic                  alt;         // sub / sra select
    logic                  lt_signed;
    logic                  lt_unsigned;

    //////////////////////////////////////////////////
    // issue/execute register

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            is_ex.valid <= 1'b0;        // payload left as is
        end else if (!hold) begin
            is_ex <= issue;
        end
    end

    //////////////////////////////////////////////////
    // decode and compute

    assign inst      = is_ex.inst;
    assign is_op     = (inst.r.opcode == `OPC_OP);
    assign is_op_imm = (inst.i.opcode == `OPC_OP_IMM);
    assign alt       = inst.r.funct7[`F7_ALT];  // imm[10] under OP-IMM

    // second operand, sign-extended imm for OP-IMM
    assign opa = is_ex.rs1_value;
    assign opb = is_op_imm ? {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm}
                           : is_ex.rs2_value;
    assign shamt = opb[4:0];    // low 5 bits for both forms

    assign lt_signed   = ($signed(opa) < $signed(opb));
    assign lt_unsigned = (opa < opb);

    always_comb begin
        alu_out = '0;   // unknown opcode
        if (is_op || is_op_imm) begin
            case (inst.r.funct3)
                3'b000: begin
                    // no subi, alt only counts for OP
                    if (is_op && alt) begin
                        alu_out = opa - opb;
                    end else begin
                        alu_out = opa + opb;
                    end
                end
                3'b001: alu_out = opa << shamt;
                3'b010: alu_out = {{(`XLEN-1){1'b0}}, lt_signed};
                3'b011: alu_out = {{(`XLEN-1){1'b0}}, lt_unsigned};
                3'b100: alu_out = opa ^ opb;
                3'b101: begin
                    if (alt) begin
                        alu_out = $signed(opa) >>> shamt;  // sra / srai
                    end else begin
                        alu_out = opa >> shamt;
                    end
                end
                3'b110: alu_out = opa | opb;
                default: alu_out = opa & opb;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // execute/complete register

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result.valid <= 1'b0;
        end else if (!hold) begin
            result.valid <= is_ex.valid;    // bubbles clear it
            result.tag   <= is_ex.tag;
            result.value <= alu_out;
        end
    end

endmodule

//--- hw/cdb_arbiter.sv
// complete stage, two CDB lanes granted by fixed priority mult > alu0 > alu1
// purely combinational, only alu1 can be refused a lane
`include "fu_cfg.svh"

module cdb_arbiter (
    input  fu_pkg::ex_cp_packet_t       alu0_result,
    input  fu_pkg::ex_cp_packet_t       alu1_result,
    input  fu_pkg::ex_cp_packet_t       mult_result,
    output fu_pkg::cdb_packet_t   [1:0] cdb,
    output logic                        alu1_stall
);

    fu_pkg::ex_cp_packet_t cand [3];    // index 0 is highest priority
    logic [1:0]            slot;        // next free bus lane

    //////////////////////////////////////////////////
    // lane grant

    always_comb begin
        cand[0] = mult_result;
        cand[1] = alu0_result;
        cand[2] = alu1_result;
        cdb     = '0;
        slot    = 2'd0;
        // first valid takes cdb[0], second cdb[1]
        for (int i = 0; i < 3; i++) begin
            if (cand[i].valid && (slot < 2'd2)) begin
                cdb[slot[0]].valid = 1'b1;
                cdb[slot[0]].tag   = cand[i].tag;
                cdb[slot[0]].value = cand[i].value;
                slot               = slot + 2'd1;
            end
        end
    end

    // three results, two lanes, alu1 waits
    assign alu1_stall = mult_result.valid & alu0_result.valid & alu1_result.valid;

endmodule

//--- hw/fu_cluster.sv
// functional-unit cluster: two ALU lanes, one multiplier, two-lane CDB
// upstream must hold alu1_issue while alu1_stall is high
`include "fu_cfg.svh"

module fu_cluster (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        squash,      // clears all in-flight work
    input  fu_pkg::is_ex_packet_t       alu0_issue,
    input  fu_pkg::is_ex_packet_t       alu1_issue,
    input  fu_pkg::is_ex_packet_t       mult_issue,
    output logic                        alu1_stall,
    output fu_pkg::cdb_packet_t   [1:0] cdb
);

    fu_pkg::ex_cp_packet_t alu0_result;
    fu_pkg::ex_cp_packet_t alu1_result;
    fu_pkg::ex_cp_packet_t mult_result;
    logic                  alu0_hold;

    // lane 0 always wins a slot after mult
    assign alu0_hold = 1'b0;

    alu_lane alu_lane_0 (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .hold   (alu0_hold),
        .issue  (alu0_issue),
        .result (alu0_result)
    );

    alu_lane alu_lane_1 (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .hold   (alu1_stall),   // back-pressure from complete stage
        .issue  (alu1_issue),
        .result (alu1_result)
    );

    mult_pipe mult_pipe_0 (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .issue  (mult_issue),
        .result (mult_result)
    );

    cdb_arbiter cdb_arbiter_0 (
        .alu0_result (alu0_result),
        .alu1_result (alu1_result),
        .mult_result (mult_result),
        .cdb         (cdb),
        .alu1_stall  (alu1_stall)
    );

endmodule

//--- hw/fu_pkg.sv
// types shared by the FU cluster lanes and the complete stage
// widths follow fu_cfg.svh, instruction word is RV32 only
`include "fu_cfg.svh"

package fu_pkg;

    typedef logic [`XLEN-1:0]     data_t;   // one data word
    typedef logic [`TAG_BITS-1:0] tag_t;    // rob tag

    //////////////////////////////////////////////////
    // instruction word views

    // register-register layout, function fields live here
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // immediate layout, same low 20 bits as r view
    typedef struct packed {
        logic [11:0] imm;   // sign bit at [11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // one 32-bit word, decoded both ways by the alu
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_word_t;

    //////////////////////////////////////////////////
    // pipeline packets

    typedef struct packed {
        logic       valid;      // strobe, one packet per cycle
        tag_t       tag;
        data_t      rs1_value;
        data_t      rs2_value;
        inst_word_t inst;
    } is_ex_packet_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_packet_t;

    // lane result waiting for a bus slot
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } ex_cp_packet_t;

endpackage

//--- hw/mult_pipe.sv
// multiplier lane, fully pipelined and never stalled
// result is the low XLEN bits of rs1 * rs2, ready MULT_STAGES cycles after issue reg
`include "fu_cfg.svh"

module mult_pipe (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  squash,
    input  fu_pkg::is_ex_packet_t issue,
    output fu_pkg::ex_cp_packet_t result
);

    fu_pkg::is_ex_packet_t   is_ex;                     // issue/execute register
    fu_pkg::data_t           product;
    logic [`MULT_STAGES-1:0] stage_valid;
    fu_pkg::tag_t            stage_tag  [`MULT_STAGES];
    fu_pkg::data_t           stage_prod [`MULT_STAGES];

    //////////////////////////////////////////////////
    // issue/execute register

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            is_ex.valid <= 1'b0;
        end else begin
            is_ex <= issue;     // no hold, mult always owns cdb[0]
        end
    end

    // 32x32 into a 32-bit result, upper half dropped
    // later stages give retiming room to spread the array
    assign product = is_ex.rs1_value * is_ex.rs2_value;

    //////////////////////////////////////////////////
    // product pipeline

    // valid chain, cleared by squash at every depth
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= is_ex.valid;
            for (int s = 1; s < `MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // tag and product just shift along
    always_ff @(posedge clock) begin
        stage_tag[0]  <= is_ex.tag;
        stage_prod[0] <= product;
        for (int s = 1; s < `MULT_STAGES; s++) begin
            stage_tag[s]  <= stage_tag[s-1];
            stage_prod[s] <= stage_prod[s-1];
        end
    end

    // last stage acts as the execute/complete register
    assign result = '{
        valid: stage_valid[`MULT_STAGES-1],
        tag:   stage_tag[`MULT_STAGES-1],
        value: stage_prod[`MULT_STAGES-1]
    };

endmodule

//--- include/fu_cfg.svh
// build-time settings shared by every FU cluster file
// decode assumes XLEN 32 and the RV32 OP / OP-IMM encodings; MULT_STAGES >= 1
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

//////////////////////////////////////////////////
// datapath widths

`define XLEN        32
// rob tag riding along with each instruction
`define TAG_BITS    6

//////////////////////////////////////////////////
// multiplier depth, product stages after issue/execute reg

`define MULT_STAGES 3

//////////////////////////////////////////////////
// decode constants

`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
// funct7 bit picking sub / sra
`define F7_ALT      5

`endif

//--- verif/clock_gen.sv
// testbench clock and synchronous active-high reset
// reset covers the first RESET_CYCLES rising edges
module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    int edges = 0;  // rising edges seen so far

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (edges < RESET_CYCLES) begin
            edges <= edges + 1;
        end
    end

    assign reset = (edges < RESET_CYCLES);  // drops after the last reset edge

endmodule

//--- verif/fu_checker.sv
// complete-stage properties, bound into the cluster top
// fail_count is read back by the testbench at the end of the run
module fu_checker (
    input logic                      clock,
    input logic                      reset,
    input fu_pkg::ex_cp_packet_t     alu0_result,
    input fu_pkg::ex_cp_packet_t     alu1_result,
    input fu_pkg::ex_cp_packet_t     mult_result,
    input fu_pkg::cdb_packet_t [1:0] cdb,
    input logic                      alu1_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // tags are unique while in flight
    a_tag_unique: assert property (@(posedge clock) disable iff (reset)
        (cdb[0].valid && cdb[1].valid) |-> (cdb[0].tag != cdb[1].tag))
        else begin
            $error("both cdb lanes carry tag %0d", cdb[0].tag);
            fail_count++;
        end

    // stall only when three results compete, mult and alu0 then own the bus
    a_stall_cause: assert property (@(posedge clock) disable iff (reset)
        alu1_stall |-> (mult_result.valid && alu0_result.valid && alu1_result.valid
                        && cdb[0].valid && (cdb[0].tag == mult_result.tag)
                        && cdb[1].valid && (cdb[1].tag == alu0_result.tag)))
        else begin
            $error("alu1_stall high without three pending results on mult and alu0 lanes");
            fail_count++;
        end

    a_lane_order: assert property (@(posedge clock) disable iff (reset)
        cdb[1].valid |-> cdb[0].valid)
        else begin
            $error("cdb[1] valid while cdb[0] idle");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !(cdb[0].valid || cdb[1].valid || alu1_stall))
        else begin
            $error("bus or stall active in the first cycle after reset");
            fail_count++;
        end

endmodule

//--- verif/fu_tb.sv
// random-stimulus testbench for the FU cluster, cycle-level model of all three lanes
// assumes XLEN 32; assertion hits are only counted if the simulator keeps running on $error
`include "fu_cfg.svh"

module fu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int MS           = `MULT_STAGES;
    localparam int IDLE         = 3;      // quiet cycles after reset
    localparam int NUM_CYCLES   = 400;    // cycles with random issue
    localparam int DRAIN        = 12;     // lets the pipes empty
    localparam int END_CYCLE    = IDLE + NUM_CYCLES + DRAIN;
    localparam int TEST_CYCLES  = RESET_CYCLES + END_CYCLE;

    logic                      clock;
    logic                      reset;
    logic                      squash;
    fu_pkg::is_ex_packet_t     alu0_issue;
    fu_pkg::is_ex_packet_t     alu1_issue;
    fu_pkg::is_ex_packet_t     mult_issue;
    logic                      alu1_stall;
    fu_pkg::cdb_packet_t [1:0] cdb;

    logic [31:0]  lfsr       = 32'hb4222295;
    fu_pkg::tag_t next_tag   = '0;      // running tag counter
    int           cyc        = 0;
    logic         stall_seen = 1'b0;    // alu1_stall of the cycle just ended
    int           errors     = 0;
    int           beats      = 0;       // valid bus beats matched
    int           accepted   = 0;
    int           dropped    = 0;       // valid packets killed by squash
    int           assert_fails;

    // model of the lane registers, value already computed at issue
    fu_pkg::ex_cp_packet_t mm_ix;
    fu_pkg::ex_cp_packet_t mm_st [MS];
    fu_pkg::ex_cp_packet_t m0_ix;
    fu_pkg::ex_cp_packet_t m0_cp;
    fu_pkg::ex_cp_packet_t m1_ix;
    fu_pkg::ex_cp_packet_t m1_cp;

    clock_gen #(.PERIOD_NS(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen_0 (
        .clock (clock),
        .reset (reset)
    );

    fu_cluster i_fu_cluster (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .alu0_issue (alu0_issue),
        .alu1_issue (alu1_issue),
        .mult_issue (mult_issue),
        .alu1_stall (alu1_stall),
        .cdb        (cdb)
    );

    bind fu_cluster fu_checker fu_checker_0 (
        .clock       (clock),
        .reset       (reset),
        .alu0_result (alu0_result),
        .alu1_result (alu1_result),
        .mult_result (mult_result),
        .cdb         (cdb),
        .alu1_stall  (alu1_stall)
    );

    //////////////////////////////////////////////////
    // random source and reference model

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // RV32 OP / OP-IMM semantics, anything else completes with 0
    function automatic fu_pkg::data_t alu_ref(input fu_pkg::is_ex_packet_t p);
        fu_pkg::data_t a;
        fu_pkg::data_t b;
        logic [4:0]    sh;
        logic          alt;
        logic          use_sub;
        a   = p.rs1_value;
        alt = p.inst.r.funct7[`F7_ALT];     // imm[10] in the i view
        if (p.inst.r.opcode == `OPC_OP) begin
            b       = p.rs2_value;
            use_sub = alt;
        end else if (p.inst.i.opcode == `OPC_OP_IMM) begin
            b       = {{20{p.inst.i.imm[11]}}, p.inst.i.imm};
            use_sub = 1'b0;                 // no subi
        end else begin
            return '0;
        end
        sh = b[4:0];
        case (p.inst.r.funct3)
            3'd0: return use_sub ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic fu_pkg::ex_cp_packet_t expect_alu(input fu_pkg::is_ex_packet_t p);
        return '{valid: p.valid, tag: p.tag, value: alu_ref(p)};
    endfunction

    function automatic fu_pkg::ex_cp_packet_t expect_mult(input fu_pkg::is_ex_packet_t p);
        logic [63:0] full;
        full = {32'd0, p.rs1_value} * {32'd0, p.rs2_value};   // full product
        return '{valid: p.valid, tag: p.tag, value: full[31:0]};   // low word only
    endfunction

    // legal encodings only: alt bit only where sub / sra exist
    task automatic make_packet(input logic active, output fu_pkg::is_ex_packet_t p);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic        shift;
        p = '0;
        draw(1, r);
        p.valid = r[0] & active;
        draw(3, r);
        f3 = r[2:0];
        draw(1, r);
        alt = r[0];
        draw(32, p.rs1_value);
        draw(32, p.rs2_value);
        draw(12, r);
        shift = (f3 == 3'd1) || (f3 == 3'd5);
        p.inst.i.imm    = r[11:0];
        p.inst.i.funct3 = f3;
        draw(1, r);
        if (r[0]) begin
            p.inst.r.opcode = `OPC_OP;
            p.inst.r.funct7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        end else begin
            p.inst.i.opcode = `OPC_OP_IMM;
            if (shift) begin
                p.inst.r.funct7 = (alt && f3 == 3'd5) ? 7'h20 : 7'h00;  // srai
            end
        end
        if (p.valid) begin
            p.tag = next_tag;
            next_tag++;
        end
    endtask

    task automatic clear_model();
        mm_ix = '0;
        for (int s = 0; s < MS; s++) begin
            mm_st[s] = '0;
        end
        m0_ix = '0;
        m0_cp = '0;
        m1_ix = '0;
        m1_cp = '0;
    endtask

    function automatic int live_count();
        int n;
        n = int'(mm_ix.valid) + int'(m0_ix.valid) + int'(m0_cp.valid);
        n = n + int'(m1_ix.valid) + int'(m1_cp.valid);
        for (int s = 0; s < MS; s++) begin
            n = n + int'(mm_st[s].valid);
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks

    task automatic check_cdb(input int lane, input fu_pkg::cdb_packet_t got,
                             input fu_pkg::cdb_packet_t exp);
        if ((got.valid !== exp.valid) ||
            (exp.valid && ((got.tag !== exp.tag) || (got.value !== exp.value)))) begin
            errors++;
            $display("FAIL %0t ns: cdb[%0d] got v=%b tag=%0d val=%h, expected v=%b tag=%0d val=%h",
                     $time, lane, got.valid, got.tag, got.value, exp.valid, exp.tag, exp.value);
        end else if (got.valid) begin
            beats++;
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: alu1_stall is %b, expected %b", $time, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus, driven on the rising edge

    initial begin
        squash     = 1'b0;
        alu0_issue = '0;
        alu1_issue = '0;
        mult_issue = '0;
    end

    always @(posedge clock) begin : stimulus
        fu_pkg::is_ex_packet_t p;
        logic                  active;
        if (!reset) begin
            active = (cyc >= IDLE) && (cyc < IDLE + NUM_CYCLES);
            cyc <= cyc + 1;
            make_packet(active, p);
            alu0_issue <= p;
            make_packet(active, p);
            mult_issue <= p;
            if (!stall_seen || squash) begin    // refused packet stays on the port
                make_packet(active, p);
                alu1_issue <= p;
            end
            squash <= (cyc == IDLE + 100) || (cyc == IDLE + 217) || (cyc == IDLE + 318);
        end
    end

    //////////////////////////////////////////////////
    // model step and checks, on the falling edge

    always @(negedge clock) begin : model_step
        fu_pkg::ex_cp_packet_t cand [3];    // priority order
        fu_pkg::cdb_packet_t   exp_cdb [2];
        logic                  exp_stall;
        int                    slot;
        if (reset) begin
            clear_model();
        end else begin
            cand[0]    = mm_st[MS-1];
            cand[1]    = m0_cp;
            cand[2]    = m1_cp;
            exp_cdb[0] = '0;
            exp_cdb[1] = '0;
            slot       = 0;
            for (int k = 0; k < 3; k++) begin
                if (cand[k].valid && slot < 2) begin
                    exp_cdb[slot] = fu_pkg::cdb_packet_t'(cand[k]);
                    slot++;
                end
            end
            exp_stall = cand[0].valid & cand[1].valid & cand[2].valid;
            check_cdb(0, cdb[0], exp_cdb[0]);
            check_cdb(1, cdb[1], exp_cdb[1]);
            check_stall(alu1_stall, exp_stall);
            stall_seen = alu1_stall;
            if (squash) begin
                dropped += live_count() - slot;    // results on the bus now still went out
                clear_model();
            end else begin
                for (int s = MS - 1; s > 0; s--) begin
                    mm_st[s] = mm_st[s-1];
                end
                mm_st[0] = mm_ix;
                mm_ix    = expect_mult(mult_issue);
                m0_cp    = m0_ix;
                m0_ix    = expect_alu(alu0_issue);
                if (mult_issue.valid) accepted++;
                if (alu0_issue.valid) accepted++;
                if (!exp_stall) begin   // lane 1 frozen under stall
                    m1_cp = m1_ix;
                    m1_ix = expect_alu(alu1_issue);
                    if (alu1_issue.valid) accepted++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // end of run and watchdog

    initial begin
        wait (cyc >= END_CYCLE);
        assert_fails = i_fu_cluster.fu_checker_0.fail_count;
        if (beats == 0) begin
            errors++;
            $display("no result ever reached the bus");
        end
        if (beats != accepted - dropped) begin
            errors++;
            $display("%0d packets accepted and %0d squashed, but %0d broadcast",
                     accepted, dropped, beats);
        end
        $display("errors: %0d from compares, %0d from assertions, %0d bus beats checked",
                 errors, assert_fails, beats);
        if (errors + assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 20) * PERIOD);
        $display("watchdog expired at %0t ns before the test reached its end", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule
